/* src/cnn_defs.svh */
`ifndef CNN_DEFS_SVH
`define CNN_DEFS_SVH

// input geometry
`define CNN_CHANNELS 8
`define CNN_KSIZE 3
`define CNN_TILE 4

// one coefficient per kernel word, two pixels per image word
`define CNN_KERNEL_WORDS (`CNN_CHANNELS * `CNN_KSIZE * `CNN_KSIZE)
`define CNN_IMAGE_WORDS (`CNN_CHANNELS * `CNN_TILE * `CNN_TILE / 2)

// right shift on a rectified sum
`define CNN_SHIFT 3

// tiles convolved with one kernel set
`define CNN_TILES_PER_KERNEL 4

`endif

/* src/cnn_types_pkg.sv */
`default_nettype none

package cnn_types_pkg;

    // kernel coefficient, low byte of a kernel word
    typedef logic signed [7:0] coef_t;

    typedef logic signed [7:0] pixel_t;

    // hi sits in the upper byte and holds the even column
    typedef struct packed {
        pixel_t hi;
        pixel_t lo;
    } pixel_pair_t;

    // 72 products of 8x8 bits, with headroom
    typedef logic signed [22:0] acc_t;

    // rectified, scaled and clipped result
    typedef logic [6:0] pooled_t;

endpackage

`default_nettype wire

/* src/cnn_ctrl_pkg.sv */
`default_nettype none

`include "cnn_defs.svh"

package cnn_ctrl_pkg;

    typedef enum logic [1:0] {
        KERNEL_LOAD,
        IMAGE_LOAD,
        COMPUTE
    } load_phase_e;

    // word address inside the kernel phase, 0..71
    typedef logic [$clog2(`CNN_KERNEL_WORDS)-1:0] kaddr_t;

    // word address inside the image phase, 0..63
    typedef logic [$clog2(`CNN_IMAGE_WORDS)-1:0] iaddr_t;

endpackage

`default_nettype wire

/* src/conv_if.sv */
`default_nettype none

`include "cnn_defs.svh"

interface conv_if
    import cnn_types_pkg::*;
();

    logic        start;    // loader -> engine, one cycle
    logic        done;     // engine -> loader, with o_valid

    coef_t       coefs  [`CNN_KERNEL_WORDS];
    pixel_pair_t pixels [`CNN_IMAGE_WORDS];

    modport loader_mp (
        output start,
        input  done
    );

    modport kstore_mp (
        output coefs
    );

    modport istore_mp (
        output pixels
    );

    modport engine_mp (
        input  start,
        input  coefs,
        input  pixels,
        output done
    );

endinterface

`default_nettype wire

/* src/sample_loader.sv */
`default_nettype none

`include "cnn_defs.svh"

module sample_loader
    import cnn_types_pkg::*, cnn_ctrl_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rst,
    input  wire logic        i_valid,
    input  wire logic [15:0] i_data,
    output logic             o_kwe,
    output kaddr_t           o_kaddr,
    output coef_t            o_kentry,
    output logic             o_iwe,
    output iaddr_t           o_iaddr,
    output pixel_pair_t      o_ientry,
    conv_if.loader_mp        bus
);

    localparam int TILE_W = $clog2(`CNN_TILES_PER_KERNEL);

    load_phase_e       phase;
    load_phase_e       wr_phase;
    kaddr_t            wcnt;        // shared by both load phases
    logic [TILE_W-1:0] tile_cnt;
    logic              start_q;
    logic              last_tile;
    logic              kernel_last;
    logic              image_last;

    assign last_tile   = tile_cnt == TILE_W'(`CNN_TILES_PER_KERNEL - 1);
    assign kernel_last = wcnt == kaddr_t'(`CNN_KERNEL_WORDS - 1);
    assign image_last  = wcnt == kaddr_t'(`CNN_IMAGE_WORDS - 1);

    // the done cycle already counts as the next load phase,
    // so a source reacting to o_valid loses no word
    always_comb
    begin
        wr_phase = phase;
        if (phase == COMPUTE && bus.done)
            wr_phase = last_tile ? KERNEL_LOAD : IMAGE_LOAD;
    end

    assign o_kwe    = i_valid && (wr_phase == KERNEL_LOAD);
    assign o_iwe    = i_valid && (wr_phase == IMAGE_LOAD);
    assign o_kaddr  = wcnt;
    assign o_iaddr  = iaddr_t'(wcnt);
    assign o_kentry = coef_t'(i_data[7:0]);    // high byte unused
    assign o_ientry = pixel_pair_t'(i_data);

    assign bus.start = start_q;

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            phase    <= KERNEL_LOAD;
            wcnt     <= '0;
            tile_cnt <= '0;
            start_q  <= 1'b0;
        end
        else
        begin
            start_q <= 1'b0;

            if (phase == COMPUTE && bus.done)
            begin
                phase    <= wr_phase;
                tile_cnt <= last_tile ? '0 : tile_cnt + 1'b1;
            end

            if (o_kwe)
            begin
                if (kernel_last)
                begin
                    wcnt  <= '0;
                    phase <= IMAGE_LOAD;
                end
                else
                    wcnt <= wcnt + 1'b1;
            end

            if (o_iwe)
            begin
                if (image_last)
                begin
                    wcnt    <= '0;
                    phase   <= COMPUTE;
                    start_q <= 1'b1;    // tile complete
                end
                else
                    wcnt <= wcnt + 1'b1;
            end
        end
    end

    a_one_store: assert property (@(posedge i_clk) disable iff (!i_rst)
        !(o_kwe && o_iwe));

endmodule

`default_nettype wire

/* src/sample_store.sv */
`default_nettype none

`include "cnn_defs.svh"

module sample_store #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = `CNN_KERNEL_WORDS
) (
    input  wire logic                     i_clk,
    input  wire logic                     i_rst,
    input  wire logic                     i_we,
    input  wire logic [$clog2(DEPTH)-1:0] i_addr,
    input  wire T                         i_entry,
    conv_if                               bus
);

    T mem [DEPTH];

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            for (int i = 0; i < DEPTH; i++)
                mem[i] <= '0;
        end
        else if (i_we)
            mem[i_addr] <= i_entry;
    end

    // the depth tells which side of the interface this store feeds
    if (DEPTH == `CNN_KERNEL_WORDS)
    begin : g_kernel
        assign bus.coefs = mem;
    end
    else
    begin : g_image
        assign bus.pixels = mem;
    end

    a_addr_range: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_we |-> int'(i_addr) < DEPTH);

endmodule

`default_nettype wire

/* src/conv_pool_engine.sv */
`default_nettype none

`include "cnn_defs.svh"

module conv_pool_engine
    import cnn_types_pkg::*;
(
    input  wire logic  i_clk,
    input  wire logic  i_rst,
    conv_if.engine_mp  bus,
    output logic       o_valid,
    output logic [7:0] o_data
);

    localparam int WIN_SIDE  = `CNN_TILE - `CNN_KSIZE + 1;
    localparam int WINDOWS   = WIN_SIDE * WIN_SIDE;
    localparam int ROW_WORDS = `CNN_TILE / 2;
    localparam int CH_WORDS  = `CNN_TILE * ROW_WORDS;

    logic [$clog2(WINDOWS)-1:0] pos;    // bit 0 column offset, bit 1 row offset
    logic                       busy;
    acc_t                       acc;
    pooled_t                    res;
    pooled_t                    max_q;
    pooled_t                    pool_next;
    logic                       valid_q;
    logic [7:0]                 data_q;

    // 72 products for the window at pos
    always_comb
    begin
        int                 row;
        int                 col;
        int                 widx;
        pixel_pair_t        pair;
        pixel_t             pix;
        coef_t              coef;
        logic signed [15:0] prod;

        acc = '0;
        for (int c = 0; c < `CNN_CHANNELS; c++)
        begin
            for (int kr = 0; kr < `CNN_KSIZE; kr++)
            begin
                for (int kc = 0; kc < `CNN_KSIZE; kc++)
                begin
                    row  = int'(pos[1]) + kr;
                    col  = int'(pos[0]) + kc;
                    widx = c * CH_WORDS + row * ROW_WORDS + col / 2;
                    pair = bus.pixels[widx];
                    pix  = col[0] ? pair.lo : pair.hi;    // even column in hi
                    coef = bus.coefs[(c * `CNN_KSIZE + kr) * `CNN_KSIZE + kc];
                    prod = coef * pix;
                    acc  = acc + acc_t'(prod);
                end
            end
        end
    end

    // relu, scale, clip to 7 bits
    always_comb
    begin
        acc_t scaled;

        scaled = acc >>> `CNN_SHIFT;
        if (acc < 0)
            res = '0;
        else if (scaled > 127)
            res = '1;
        else
            res = pooled_t'(scaled);
    end

    assign pool_next = (res > max_q) ? res : max_q;

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            busy    <= 1'b0;
            pos     <= '0;
            max_q   <= '0;
            valid_q <= 1'b0;
            data_q  <= '0;
        end
        else
        begin
            valid_q <= 1'b0;
            data_q  <= '0;
            if (bus.start)
            begin
                busy  <= 1'b1;
                pos   <= '0;
                max_q <= '0;
            end
            else if (busy)
            begin
                max_q <= pool_next;
                pos   <= pos + 1'b1;
                if (int'(pos) == WINDOWS - 1)
                begin
                    busy    <= 1'b0;
                    valid_q <= 1'b1;
                    data_q  <= {1'b0, pool_next};
                end
            end
        end
    end

    assign o_valid  = valid_q;
    assign o_data   = data_q;
    assign bus.done = valid_q;    // loader leaves COMPUTE on this

    a_valid_pulse: assert property (@(posedge i_clk) disable iff (!i_rst)
        o_valid |=> !o_valid);

    a_start_idle: assert property (@(posedge i_clk) disable iff (!i_rst)
        bus.start |-> !busy);

endmodule

`default_nettype wire

/* src/cnn_core.sv */
`default_nettype none

`include "cnn_defs.svh"

module cnn_core
    import cnn_types_pkg::*, cnn_ctrl_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rst,
    input  wire logic        i_valid,
    input  wire logic [15:0] i_data,
    output logic             o_valid,
    output logic [7:0]       o_data
);

    logic        kwe;
    kaddr_t      kaddr;
    coef_t       kentry;
    logic        iwe;
    iaddr_t      iaddr;
    pixel_pair_t ientry;

    conv_if cif ();

    sample_loader u_loader (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_valid  (i_valid),
        .i_data   (i_data),
        .o_kwe    (kwe),
        .o_kaddr  (kaddr),
        .o_kentry (kentry),
        .o_iwe    (iwe),
        .o_iaddr  (iaddr),
        .o_ientry (ientry),
        .bus      (cif.loader_mp)
    );

    // 72 coefficients, 8 channels of 3x3
    sample_store #(
        .T     (coef_t),
        .DEPTH (`CNN_KERNEL_WORDS)
    ) kernel_store (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_we    (kwe),
        .i_addr  (kaddr),
        .i_entry (kentry),
        .bus     (cif.kstore_mp)
    );

    // 64 pixel pairs, 8 channels of 4x4
    sample_store #(
        .T     (pixel_pair_t),
        .DEPTH (`CNN_IMAGE_WORDS)
    ) image_store (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_we    (iwe),
        .i_addr  (iaddr),
        .i_entry (ientry),
        .bus     (cif.istore_mp)
    );

    conv_pool_engine u_engine (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .bus     (cif.engine_mp),
        .o_valid (o_valid),
        .o_data  (o_data)
    );

endmodule

`default_nettype wire

/* verification/cnn_core_tests.svh */
task automatic fill_kernel(input int lo, input int hi);
    for (int k = 0; k < `CNN_KERNEL_WORDS; k++)
        kern[k] = coef_t'(rand_range(lo, hi));
endtask

task automatic fill_tile(input int lo, input int hi);
    for (int c = 0; c < `CNN_CHANNELS; c++)
        for (int r = 0; r < `CNN_TILE; r++)
            for (int col = 0; col < `CNN_TILE; col++)
                img[c][r][col] = pixel_t'(rand_range(lo, hi));
endtask

task automatic test_reset_idle();
    apply_reset();
    repeat (20)
    begin
        @(negedge i_clk);
        if (o_valid !== 1'b0 || o_data !== 8'h00)
        begin
            n_failure++;
            $display("output active after reset with no input");
        end
    end
endtask

task automatic test_known_tile();
    logic [7:0] data;

    apply_reset();
    for (int k = 0; k < `CNN_KERNEL_WORDS; k++)
        kern[k] = (k % 9 == 4) ? coef_t'(1) : coef_t'(0);    // centre tap only
    fill_tile(2, 2);
    load_kernel();
    run_tile(0, data);
    check_pooled(data, pooled_t'(2), "known tile");
endtask

// positive kernel, so the pixel range picks zero, mid or saturated
task automatic test_random_tiles();
    logic [7:0] data;

    apply_reset();
    fill_kernel(0, 15);
    load_kernel();
    fill_tile(-128, 127);
    run_tile(0, data);
    check_pooled(data, expected_pool(), "random tile");
    fill_tile(-128, -1);
    run_tile(0, data);
    check_pooled(data, expected_pool(), "negative tile");
    fill_tile(64, 127);
    run_tile(0, data);
    check_pooled(data, expected_pool(), "saturating tile");
    fill_tile(-3, 4);
    run_tile(0, data);
    check_pooled(data, expected_pool(), "mid range tile");
endtask

task automatic test_kernel_reload();
    logic [7:0] data;

    fill_kernel(-128, 127);
    load_kernel();
    fill_tile(-3, 3);
    run_tile(0, data);
    check_pooled(data, expected_pool(), "tile after kernel reload");
endtask

task automatic test_ignored_input();
    logic [7:0] data;

    apply_reset();
    fill_kernel(-128, 127);
    load_kernel();
    fill_tile(-8, 8);
    run_tile(4, data);
    check_pooled(data, expected_pool(), "tile with junk during compute");
    fill_tile(-8, 8);
    run_tile(0, data);
    check_pooled(data, expected_pool(), "tile after junk");
endtask

/* verification/cnn_core_tb.sv */
`default_nettype none

`include "cnn_defs.svh"

module cnn_core_tb
    import cnn_types_pkg::*;
();

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 16;
    localparam int VALID_TIMEOUT = 50;
    localparam int OUT_LATENCY   = 5;    // edges after the last image word
    localparam int WIN_SIDE      = `CNN_TILE - `CNN_KSIZE + 1;

    logic        i_clk;
    logic        i_rst;
    logic        i_valid;
    logic [15:0] i_data;
    logic        o_valid;
    logic [7:0]  o_data;

    int n_mismatch;
    int n_failure;

    // reference copies of what was sent
    coef_t  kern [`CNN_KERNEL_WORDS];
    pixel_t img  [`CNN_CHANNELS][`CNN_TILE][`CNN_TILE];

    cnn_core DUT (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (i_valid),
        .i_data  (i_data),
        .o_valid (o_valid),
        .o_data  (o_data)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($urandom % 32'(hi - lo + 1));
    endfunction

    // relu, shift, clip and max over the four windows
    function automatic pooled_t expected_pool();
        int sum;
        int scaled;
        int best;

        best = 0;
        for (int wr = 0; wr < WIN_SIDE; wr++)
        begin
            for (int wc = 0; wc < WIN_SIDE; wc++)
            begin
                sum = 0;
                for (int c = 0; c < `CNN_CHANNELS; c++)
                    for (int kr = 0; kr < `CNN_KSIZE; kr++)
                        for (int kc = 0; kc < `CNN_KSIZE; kc++)
                            sum += int'(kern[(c * `CNN_KSIZE + kr) * `CNN_KSIZE + kc])
                                   * int'(img[c][wr + kr][wc + kc]);
                scaled = (sum < 0) ? 0 : (sum >>> `CNN_SHIFT);
                if (scaled > 127)
                    scaled = 127;
                if (scaled > best)
                    best = scaled;
            end
        end
        return pooled_t'(best);
    endfunction

    task automatic check_pooled(input logic [7:0] got, input pooled_t exp, input string what);
        if (got !== {1'b0, exp})
        begin
            n_mismatch++;
            $display("mismatch at %0t: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(negedge i_clk);
        i_rst   = 1'b0;
        i_valid = 1'b0;
        repeat (RESET_CYCLES) @(negedge i_clk);
        i_rst = 1'b1;
    endtask

    task automatic send_word(input logic [15:0] word);
        @(negedge i_clk);
        i_valid = 1'b1;
        i_data  = word;
    endtask

    task automatic load_kernel();
        for (int k = 0; k < `CNN_KERNEL_WORDS; k++)
            send_word({8'(rand_range(0, 255)), kern[k]});    // junk high byte
    endtask

    task automatic load_image();
        for (int c = 0; c < `CNN_CHANNELS; c++)
            for (int r = 0; r < `CNN_TILE; r++)
                for (int h = 0; h < `CNN_TILE / 2; h++)
                    send_word({img[c][r][2 * h], img[c][r][2 * h + 1]});
    endtask

    // junk words go out while the engine computes
    task automatic await_result(input int junk_cycles, output logic [7:0] data,
                                output int edges);
        int   n;
        logic seen;

        n     = 0;
        seen  = 1'b0;
        edges = -1;
        data  = '0;
        while (!seen && n < VALID_TIMEOUT)
        begin
            @(negedge i_clk);
            n++;
            if (o_valid)
            begin
                seen  = 1'b1;
                data  = o_data;
                edges = n - 1;
            end
            if (!seen && n <= junk_cycles)
            begin
                i_valid = 1'b1;
                i_data  = 16'($urandom);
            end
            else
                i_valid = 1'b0;
        end
        if (!seen)
        begin
            n_failure++;
            $display("no output valid");
        end
    endtask

    task automatic run_tile(input int junk_cycles, output logic [7:0] data);
        int edges;

        load_image();
        await_result(junk_cycles, data, edges);
        if (edges >= 0 && edges != OUT_LATENCY)
        begin
            n_failure++;
            $display("output valid came %0d edges after the last word, not %0d",
                     edges, OUT_LATENCY);
        end
        @(negedge i_clk);
        if (o_valid !== 1'b0)
        begin
            n_failure++;
            $display("output valid stayed high for more than one cycle");
        end
    endtask

    `include "cnn_core_tests.svh"

    initial
    begin
        i_rst      = 1'b0;
        i_valid    = 1'b0;
        i_data     = '0;
        n_mismatch = 0;
        n_failure  = 0;
        void'($urandom(32'h6251_6f84));

        test_reset_idle();
        test_known_tile();
        test_random_tiles();
        test_kernel_reload();    // continues from the four tiles above
        test_ignored_input();

        $display("mismatches: %0d, other failures: %0d", n_mismatch, n_failure);
        if (n_mismatch == 0 && n_failure == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+src
+incdir+verification
src/cnn_types_pkg.sv
src/cnn_ctrl_pkg.sv
src/conv_if.sv
src/sample_loader.sv
src/sample_store.sv
src/conv_pool_engine.sv
src/cnn_core.sv
verification/cnn_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the cnn_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module cnn_core_tb \
    -f build.f

sim_out=$(./obj_dir/Vcnn_core_tb)
echo "$sim_out"

if echo "$sim_out" | grep -qx "all tests passed"; then
    exit 0
else
    exit 1
fi
